// File: design/bank_issue_queue.sv
module bank_issue_queue
  import bank_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // external request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [CH_W-1:0]      req_channel_i,
  input  logic [2:0]           req_opcode_i,
  input  logic [ADDR_W-1:0]    req_addr_i,
  input  logic [WBUF_ID_W-1:0] req_wbuf_id_i,
  input  logic [ROB_W-1:0]     req_rob_i,
  input  logic [1:0]           req_state0_i,
  input  logic [1:0]           req_state1_i,
  input  logic [DATA_W-1:0]    req_fill0_i,
  input  logic [DATA_W-1:0]    req_fill1_i,
  // head entry towards the controller
  output logic                 isu_valid_o,
  output logic [2:0]           isu_opcode_o,
  output logic [ADDR_W-1:0]    isu_addr_o,
  output logic [WBUF_ID_W-1:0] isu_wbuf_id_o,
  output logic [CH_W-1:0]      isu_channel_o,
  output logic [ROB_W-1:0]     isu_rob_o,
  output logic [1:0]           isu_state0_o,
  output logic [1:0]           isu_state1_o,
  output logic [DATA_W-1:0]    isu_fill0_o,
  output logic [DATA_W-1:0]    isu_fill1_o,
  input  logic                 isu_done_i
);

  logic [2:0]           q_opcode  [2];
  logic [ADDR_W-1:0]    q_addr    [2];
  logic [WBUF_ID_W-1:0] q_wbuf_id [2];
  logic [CH_W-1:0]      q_channel [2];
  logic [ROB_W-1:0]     q_rob     [2];
  logic [1:0]           q_state0  [2];
  logic [1:0]           q_state1  [2];
  logic [DATA_W-1:0]    q_fill0   [2];
  logic [DATA_W-1:0]    q_fill1   [2];

  logic       rd_ptr_q;
  logic       wr_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_nxt;
  logic       push;
  logic       pop;

  assign push = req_valid_i & req_ready_o;
  assign pop  = isu_done_i & isu_valid_o;

  assign count_nxt = count_q + {1'b0, push} - {1'b0, pop};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_ptr_q    <= 1'b0;
      wr_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      req_ready_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q     <= count_nxt;
      // registered so it stays low while reset is applied
      req_ready_o <= (count_nxt != 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_opcode[wr_ptr_q]  <= req_opcode_i;
      q_addr[wr_ptr_q]    <= req_addr_i;
      q_wbuf_id[wr_ptr_q] <= req_wbuf_id_i;
      q_channel[wr_ptr_q] <= req_channel_i;
      q_rob[wr_ptr_q]     <= req_rob_i;
      q_state0[wr_ptr_q]  <= req_state0_i;
      q_state1[wr_ptr_q]  <= req_state1_i;
      q_fill0[wr_ptr_q]   <= req_fill0_i;
      q_fill1[wr_ptr_q]   <= req_fill1_i;
    end
  end

  assign isu_valid_o   = (count_q != 2'd0);
  assign isu_opcode_o  = q_opcode[rd_ptr_q];
  assign isu_addr_o    = q_addr[rd_ptr_q];
  assign isu_wbuf_id_o = q_wbuf_id[rd_ptr_q];
  assign isu_channel_o = q_channel[rd_ptr_q];
  assign isu_rob_o     = q_rob[rd_ptr_q];
  assign isu_state0_o  = q_state0[rd_ptr_q];
  assign isu_state1_o  = q_state1[rd_ptr_q];
  assign isu_fill0_o   = q_fill0[rd_ptr_q];
  assign isu_fill1_o   = q_fill1[rd_ptr_q];

endmodule

// File: design/bank_pkg.sv
package bank_pkg;

  // ------------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------------
  localparam int DATA_W     = 128;
  localparam int ADDR_W     = 7;
  localparam int RAM_DEPTH  = 128;
  localparam int WBUF_ID_W  = 8;
  // only the low id bits select one of the buffer entries
  localparam int WBUF_IDX_W = 3;
  localparam int CH_W       = 2;
  localparam int ROB_W      = 3;

  // ------------------------------------------------------------------------
  // request opcodes and line states
  // ------------------------------------------------------------------------
  localparam logic [2:0] OP_WRITE         = 3'd0;
  localparam logic [2:0] OP_READ          = 3'd1;
  localparam logic [2:0] OP_READ_LINEFILL = 3'd2;
  localparam logic [2:0] OP_WRITE_BACK    = 3'd3;

  localparam logic [1:0] ST_EMPTY = 2'd0;
  localparam logic [1:0] ST_SYNC  = 2'd1;
  localparam logic [1:0] ST_DIRTY = 2'd2;

  // bank address, seen as a flat ram index or as line plus offset
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [ADDR_W-2:0] set_way;
      logic              offset;
    } f;
  } bank_addr_u;

endpackage

// File: design/bank_sram_controller.sv
module bank_sram_controller
  import bank_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // head of the issue queue
  input  logic                 isu_valid_i,
  input  logic [2:0]           isu_opcode_i,
  input  logic [ADDR_W-1:0]    isu_addr_i,
  input  logic [WBUF_ID_W-1:0] isu_wbuf_id_i,
  input  logic [CH_W-1:0]      isu_channel_i,
  input  logic [ROB_W-1:0]     isu_rob_i,
  input  logic [1:0]           isu_state0_i,
  input  logic [1:0]           isu_state1_i,
  input  logic [DATA_W-1:0]    isu_fill0_i,
  input  logic [DATA_W-1:0]    isu_fill1_i,
  output logic                 isu_done_o,
  // write buffer
  output logic                 wbuf_req_valid_o,
  input  logic                 wbuf_req_ready_i,
  output logic [WBUF_ID_W-1:0] wbuf_req_id_o,
  input  logic                 wbuf_rtn_valid_i,
  input  logic [DATA_W-1:0]    wbuf_rtn_data_i,
  // data ram
  output logic                 ram_en_o,
  output logic                 ram_we_o,
  output logic [ADDR_W-1:0]    ram_addr_o,
  output logic [DATA_W-1:0]    ram_wdata_o,
  input  logic [DATA_W-1:0]    ram_rdata_i,
  // crossbar
  output logic                 xbar_valid_o,
  input  logic                 xbar_ready_i,
  output logic [CH_W-1:0]      xbar_channel_o,
  output logic [ROB_W-1:0]     xbar_rob_o,
  output logic [DATA_W-1:0]    xbar_data_o,
  // sub-memory
  output logic                 biu_valid_o,
  input  logic                 biu_ready_i,
  output logic [DATA_W-1:0]    biu_data_o,
  output logic [ADDR_W-1:0]    biu_addr_o
);

  bank_addr_u        head_addr;
  bank_addr_u        cur_addr;
  logic              is_wr;
  logic              is_rd;
  logic              is_lf;
  logic              is_wb;
  logic              is_known;
  logic [1:0]        unsel_state;
  logic              lf_two;
  logic              wb_two;
  logic              second_off;
  logic              lf_wr;
  logic              lf_send;
  logic              rd_en;
  logic              wr_en;
  logic              xbar_fire;
  logic              biu_fire;
  logic              done;
  logic [1:0]        step_q;
  logic [1:0]        step_nxt;
  logic [DATA_W-1:0] sel_fill;
  logic [DATA_W-1:0] cur_fill;
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] hold_q;
  logic              rd_fresh_q;

  // ------------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------------
  assign head_addr = isu_addr_i;

  assign is_wr    = (isu_opcode_i == OP_WRITE);
  assign is_rd    = (isu_opcode_i == OP_READ);
  assign is_lf    = (isu_opcode_i == OP_READ_LINEFILL);
  assign is_wb    = (isu_opcode_i == OP_WRITE_BACK);
  assign is_known = is_wr | is_rd | is_lf | is_wb;

  assign unsel_state = head_addr.f.offset ? isu_state0_i : isu_state1_i;

  // other offset is filled too while it is still empty
  assign lf_two = (unsel_state == ST_EMPTY);
  assign wb_two = (unsel_state == ST_DIRTY);

  // linefill step 1 and write back steps 2/3 work on the other offset
  assign second_off = is_lf ? (step_q == 2'd1) : (is_wb & step_q[1]);

  assign cur_addr.f.set_way = head_addr.f.set_way;
  assign cur_addr.f.offset  = head_addr.f.offset ^ second_off;

  assign sel_fill = head_addr.f.offset ? isu_fill1_i : isu_fill0_i;
  assign cur_fill = cur_addr.f.offset ? isu_fill1_i : isu_fill0_i;

  // ------------------------------------------------------------------------
  // step sequencing
  // ------------------------------------------------------------------------
  assign lf_wr   = isu_valid_i & is_lf & ((step_q == 2'd0) | ((step_q == 2'd1) & lf_two));
  assign lf_send = is_lf & (lf_two ? (step_q == 2'd2) : (step_q == 2'd1));

  assign xbar_valid_o = isu_valid_i & ((is_rd & (step_q == 2'd1)) | lf_send);
  assign biu_valid_o  = isu_valid_i & is_wb & step_q[0];
  assign xbar_fire    = xbar_valid_o & xbar_ready_i;
  assign biu_fire     = biu_valid_o & biu_ready_i;

  assign wbuf_req_valid_o = isu_valid_i & is_wr & (step_q == 2'd0);
  assign wbuf_req_id_o    = isu_wbuf_id_i;

  // unknown opcodes retire at once so the queue cannot stall
  assign done = isu_valid_i & ((is_wr & (step_q == 2'd2))
                             | ((is_rd | is_lf) & xbar_fire)
                             | (is_wb & biu_fire & (step_q[1] | ~wb_two))
                             | ~is_known);

  assign isu_done_o = done;

  always_comb begin
    step_nxt = step_q;
    if (done) begin
      step_nxt = 2'd0;
    end else if (isu_valid_i) begin
      if (is_wr) begin
        if (wbuf_req_valid_o & wbuf_req_ready_i) begin
          step_nxt = 2'd1;
        end else if ((step_q == 2'd1) & wbuf_rtn_valid_i) begin
          step_nxt = 2'd2;
        end
      end
      if (is_rd & (step_q == 2'd0)) begin
        step_nxt = 2'd1;
      end
      if (lf_wr) begin
        step_nxt = step_q + 2'd1;
      end
      // even steps read the ram, odd steps wait for the beat to leave
      if (is_wb & (~step_q[0] | biu_fire)) begin
        step_nxt = step_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      step_q     <= 2'd0;
      rd_fresh_q <= 1'b0;
    end else begin
      step_q     <= step_nxt;
      rd_fresh_q <= rd_en;
    end
  end

  // ------------------------------------------------------------------------
  // ram access and held read data
  // ------------------------------------------------------------------------
  assign rd_en = isu_valid_i & ((is_rd & (step_q == 2'd0)) | (is_wb & ~step_q[0]));
  assign wr_en = isu_valid_i & is_wr & (step_q == 2'd1) & wbuf_rtn_valid_i;

  assign ram_en_o    = rd_en | wr_en | lf_wr;
  assign ram_we_o    = wr_en | lf_wr;
  assign ram_addr_o  = cur_addr.raw;
  assign ram_wdata_o = is_lf ? cur_fill : wbuf_rtn_data_i;

  // capture read data in its first cycle, serve from the copy afterwards
  always_ff @(posedge clk_i) begin
    if (rd_fresh_q) begin
      hold_q <= ram_rdata_i;
    end
  end

  assign rd_data = rd_fresh_q ? ram_rdata_i : hold_q;

  assign xbar_data_o    = is_lf ? sel_fill : rd_data;
  assign xbar_channel_o = isu_channel_i;
  assign xbar_rob_o     = isu_rob_i;

  assign biu_data_o = rd_data;
  assign biu_addr_o = cur_addr.raw;

endmodule

// File: design/bank_write_buffer.sv
module bank_write_buffer
  import bank_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // load port, always accepted
  input  logic                 wb_wr_valid_i,
  input  logic [WBUF_ID_W-1:0] wb_wr_id_i,
  input  logic [DATA_W-1:0]    wb_wr_data_i,
  // fetch request from the controller
  input  logic                 wbuf_req_valid_i,
  output logic                 wbuf_req_ready_o,
  input  logic [WBUF_ID_W-1:0] wbuf_req_id_i,
  // data return, one cycle after acceptance
  output logic                 wbuf_rtn_valid_o,
  output logic [DATA_W-1:0]    wbuf_rtn_data_o
);

  logic [DATA_W-1:0] mem [2**WBUF_IDX_W];
  logic              req_fire;

  assign wbuf_req_ready_o = ~wbuf_rtn_valid_o;
  assign req_fire         = wbuf_req_valid_i & wbuf_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (wb_wr_valid_i) begin
      mem[wb_wr_id_i[WBUF_IDX_W-1:0]] <= wb_wr_data_i;
    end
  end

  // a load to the same id in the fetch cycle is seen by the next fetch
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      wbuf_rtn_data_o <= mem[wbuf_req_id_i[WBUF_IDX_W-1:0]];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wbuf_rtn_valid_o <= 1'b0;
    end else begin
      wbuf_rtn_valid_o <= req_fire;
    end
  end

endmodule

// File: design/cache_bank_top.sv
module cache_bank_top
  import bank_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // request port
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [CH_W-1:0]      req_channel_i,
  input  logic [2:0]           req_opcode_i,
  input  logic [ADDR_W-1:0]    req_addr_i,
  input  logic [WBUF_ID_W-1:0] req_wbuf_id_i,
  input  logic [ROB_W-1:0]     req_rob_i,
  input  logic [1:0]           req_state0_i,
  input  logic [1:0]           req_state1_i,
  input  logic [DATA_W-1:0]    req_fill0_i,
  input  logic [DATA_W-1:0]    req_fill1_i,
  // write buffer load
  input  logic                 wb_wr_valid_i,
  input  logic [WBUF_ID_W-1:0] wb_wr_id_i,
  input  logic [DATA_W-1:0]    wb_wr_data_i,
  // crossbar
  output logic                 xbar_valid_o,
  input  logic                 xbar_ready_i,
  output logic [CH_W-1:0]      xbar_channel_o,
  output logic [ROB_W-1:0]     xbar_rob_o,
  output logic [DATA_W-1:0]    xbar_data_o,
  // sub-memory
  output logic                 biu_valid_o,
  input  logic                 biu_ready_i,
  output logic [DATA_W-1:0]    biu_data_o,
  output logic [ADDR_W-1:0]    biu_addr_o
);

  logic                 isu_valid;
  logic                 isu_done;
  logic [2:0]           isu_opcode;
  logic [ADDR_W-1:0]    isu_addr;
  logic [WBUF_ID_W-1:0] isu_wbuf_id;
  logic [CH_W-1:0]      isu_channel;
  logic [ROB_W-1:0]     isu_rob;
  logic [1:0]           isu_state0;
  logic [1:0]           isu_state1;
  logic [DATA_W-1:0]    isu_fill0;
  logic [DATA_W-1:0]    isu_fill1;

  logic                 wbuf_req_valid;
  logic                 wbuf_req_ready;
  logic [WBUF_ID_W-1:0] wbuf_req_id;
  logic                 wbuf_rtn_valid;
  logic [DATA_W-1:0]    wbuf_rtn_data;

  logic                 ram_en;
  logic                 ram_we;
  logic [ADDR_W-1:0]    ram_addr;
  logic [DATA_W-1:0]    ram_wdata;
  logic [DATA_W-1:0]    ram_rdata;

  bank_issue_queue bank_issue_queue_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_channel_i (req_channel_i),
    .req_opcode_i  (req_opcode_i),
    .req_addr_i    (req_addr_i),
    .req_wbuf_id_i (req_wbuf_id_i),
    .req_rob_i     (req_rob_i),
    .req_state0_i  (req_state0_i),
    .req_state1_i  (req_state1_i),
    .req_fill0_i   (req_fill0_i),
    .req_fill1_i   (req_fill1_i),
    .isu_valid_o   (isu_valid),
    .isu_opcode_o  (isu_opcode),
    .isu_addr_o    (isu_addr),
    .isu_wbuf_id_o (isu_wbuf_id),
    .isu_channel_o (isu_channel),
    .isu_rob_o     (isu_rob),
    .isu_state0_o  (isu_state0),
    .isu_state1_o  (isu_state1),
    .isu_fill0_o   (isu_fill0),
    .isu_fill1_o   (isu_fill1),
    .isu_done_i    (isu_done)
  );

  bank_sram_controller bank_sram_controller_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .isu_valid_i      (isu_valid),
    .isu_opcode_i     (isu_opcode),
    .isu_addr_i       (isu_addr),
    .isu_wbuf_id_i    (isu_wbuf_id),
    .isu_channel_i    (isu_channel),
    .isu_rob_i        (isu_rob),
    .isu_state0_i     (isu_state0),
    .isu_state1_i     (isu_state1),
    .isu_fill0_i      (isu_fill0),
    .isu_fill1_i      (isu_fill1),
    .isu_done_o       (isu_done),
    .wbuf_req_valid_o (wbuf_req_valid),
    .wbuf_req_ready_i (wbuf_req_ready),
    .wbuf_req_id_o    (wbuf_req_id),
    .wbuf_rtn_valid_i (wbuf_rtn_valid),
    .wbuf_rtn_data_i  (wbuf_rtn_data),
    .ram_en_o         (ram_en),
    .ram_we_o         (ram_we),
    .ram_addr_o       (ram_addr),
    .ram_wdata_o      (ram_wdata),
    .ram_rdata_i      (ram_rdata),
    .xbar_valid_o     (xbar_valid_o),
    .xbar_ready_i     (xbar_ready_i),
    .xbar_channel_o   (xbar_channel_o),
    .xbar_rob_o       (xbar_rob_o),
    .xbar_data_o      (xbar_data_o),
    .biu_valid_o      (biu_valid_o),
    .biu_ready_i      (biu_ready_i),
    .biu_data_o       (biu_data_o),
    .biu_addr_o       (biu_addr_o)
  );

  bank_write_buffer bank_write_buffer_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .wb_wr_valid_i    (wb_wr_valid_i),
    .wb_wr_id_i       (wb_wr_id_i),
    .wb_wr_data_i     (wb_wr_data_i),
    .wbuf_req_valid_i (wbuf_req_valid),
    .wbuf_req_ready_o (wbuf_req_ready),
    .wbuf_req_id_i    (wbuf_req_id),
    .wbuf_rtn_valid_o (wbuf_rtn_valid),
    .wbuf_rtn_data_o  (wbuf_rtn_data)
  );

  // one 128 x 128 data array for both offsets of every line
  ram_sp #(
    .AW ($clog2(RAM_DEPTH)),
    .DW (DATA_W)
  ) data_ram_inst (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

// File: design/ram_sp.sv
module ram_sp #(
  parameter int AW = 7,
  parameter int DW = 128
) (
  input  logic          clk_i,
  input  logic          en_i,
  input  logic          we_i,
  input  logic [AW-1:0] addr_i,
  input  logic [DW-1:0] wdata_i,
  output logic [DW-1:0] rdata_o
);

  logic [DW-1:0] mem [2**AW];

  // read data register only moves on an enabled read
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: files.f
design/bank_pkg.sv
design/ram_sp.sv
design/bank_issue_queue.sv
design/bank_write_buffer.sv
design/bank_sram_controller.sv
design/cache_bank_top.sv
tests/bank_sram_checker.sv
tests/cache_bank_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the cache bank testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cache_bank_tb -f files.f -o sim_cache_bank \
  && ./obj_dir/sim_cache_bank > sim.log 2>&1 \
  || echo "TESTBENCH FAILED" >> sim.log

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
exit 0

// File: tests/bank_sram_checker.sv
module bank_sram_checker
  import bank_pkg::*;
(
  input logic              clk_i,
  input logic              rst_i,
  input logic              req_ready_o,
  input logic              xbar_valid_o,
  input logic              xbar_ready_i,
  input logic [CH_W-1:0]   xbar_channel_o,
  input logic [ROB_W-1:0]  xbar_rob_o,
  input logic [DATA_W-1:0] xbar_data_o,
  input logic              biu_valid_o,
  input logic              biu_ready_i,
  input logic [DATA_W-1:0] biu_data_o,
  input logic [ADDR_W-1:0] biu_addr_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // a stalled crossbar beat keeps its contents until taken
  xbar_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (xbar_valid_o && !xbar_ready_i) |=> (xbar_valid_o && $stable(xbar_data_o)
      && $stable(xbar_channel_o) && $stable(xbar_rob_o)))
    else $error("crossbar beat dropped or changed while stalled");

  biu_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (biu_valid_o && !biu_ready_i) |=> (biu_valid_o && $stable(biu_data_o)
      && $stable(biu_addr_o)))
    else $error("sub-memory beat dropped or changed while stalled");

  reset_quiet_a : assert property (@(posedge clk_i)
    rst_i |-> (!xbar_valid_o && !biu_valid_o && !req_ready_o))
    else $error("output handshake active during reset");

endmodule

bind cache_bank_top bank_sram_checker bank_sram_checker_inst (.*);

// File: tests/cache_bank_tb.sv
module cache_bank_tb
  import bank_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED           = 21976;
  localparam int N_RANDOM       = 200;
  localparam int N_LINES        = RAM_DEPTH / 2;
  localparam int N_WBUF         = 2**WBUF_IDX_W;
  // about 40 cycles for every request of the whole run
  localparam int TIMEOUT_CYCLES = (N_RANDOM + N_LINES + 20) * 40;
  localparam int XB_W           = CH_W + ROB_W + DATA_W;
  localparam int BI_W           = ADDR_W + DATA_W;

  logic                 clk_i;
  logic                 rst_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  logic [CH_W-1:0]      req_channel_i;
  logic [2:0]           req_opcode_i;
  logic [ADDR_W-1:0]    req_addr_i;
  logic [WBUF_ID_W-1:0] req_wbuf_id_i;
  logic [ROB_W-1:0]     req_rob_i;
  logic [1:0]           req_state0_i;
  logic [1:0]           req_state1_i;
  logic [DATA_W-1:0]    req_fill0_i;
  logic [DATA_W-1:0]    req_fill1_i;
  logic                 wb_wr_valid_i;
  logic [WBUF_ID_W-1:0] wb_wr_id_i;
  logic [DATA_W-1:0]    wb_wr_data_i;
  logic                 xbar_valid_o;
  logic                 xbar_ready_i;
  logic [CH_W-1:0]      xbar_channel_o;
  logic [ROB_W-1:0]     xbar_rob_o;
  logic [DATA_W-1:0]    xbar_data_o;
  logic                 biu_valid_o;
  logic                 biu_ready_i;
  logic [DATA_W-1:0]    biu_data_o;
  logic [ADDR_W-1:0]    biu_addr_o;

  // shadow state of the bank and expected output beats
  logic [DATA_W-1:0] line_mem [RAM_DEPTH];
  logic [DATA_W-1:0] wbuf_mem [N_WBUF];
  logic [XB_W-1:0]   xbar_exp_q [$];
  logic [BI_W-1:0]   biu_exp_q [$];
  logic [XB_W-1:0]   xbar_exp;
  logic [BI_W-1:0]   biu_exp;
  logic              rand_ready = 1'b0;
  int                err_cnt = 0;
  int                check_cnt = 0;
  int                test_cnt = 0;
  int                test_err_base = 0;
  int                cycle_cnt = 0;

  cache_bank_top cache_bank_top_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_channel_i  (req_channel_i),
    .req_opcode_i   (req_opcode_i),
    .req_addr_i     (req_addr_i),
    .req_wbuf_id_i  (req_wbuf_id_i),
    .req_rob_i      (req_rob_i),
    .req_state0_i   (req_state0_i),
    .req_state1_i   (req_state1_i),
    .req_fill0_i    (req_fill0_i),
    .req_fill1_i    (req_fill1_i),
    .wb_wr_valid_i  (wb_wr_valid_i),
    .wb_wr_id_i     (wb_wr_id_i),
    .wb_wr_data_i   (wb_wr_data_i),
    .xbar_valid_o   (xbar_valid_o),
    .xbar_ready_i   (xbar_ready_i),
    .xbar_channel_o (xbar_channel_o),
    .xbar_rob_o     (xbar_rob_o),
    .xbar_data_o    (xbar_data_o),
    .biu_valid_o    (biu_valid_o),
    .biu_ready_i    (biu_ready_i),
    .biu_data_o     (biu_data_o),
    .biu_addr_o     (biu_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [DATA_W-1:0] rand_word();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  // expected beats of one request, shadow arrays updated in issue order
  function automatic void predict(input logic [2:0] op, input logic [ADDR_W-1:0] addr,
                                  input logic [WBUF_ID_W-1:0] id, input logic [CH_W-1:0] ch,
                                  input logic [ROB_W-1:0] rob, input logic [1:0] s0,
                                  input logic [1:0] s1, input logic [DATA_W-1:0] f0,
                                  input logic [DATA_W-1:0] f1);
    logic [ADDR_W-1:0] other;
    logic [1:0]        unsel;
    logic [DATA_W-1:0] sel_fill;
    logic [DATA_W-1:0] other_fill;
    other      = {addr[ADDR_W-1:1], ~addr[0]};
    unsel      = addr[0] ? s0 : s1;
    sel_fill   = addr[0] ? f1 : f0;
    other_fill = addr[0] ? f0 : f1;
    case (op)
      OP_WRITE: line_mem[addr] = wbuf_mem[id[WBUF_IDX_W-1:0]];
      OP_READ: xbar_exp_q.push_back({ch, rob, line_mem[addr]});
      OP_READ_LINEFILL: begin
        line_mem[addr] = sel_fill;
        if (unsel == ST_EMPTY) begin
          line_mem[other] = other_fill;
        end
        xbar_exp_q.push_back({ch, rob, sel_fill});
      end
      OP_WRITE_BACK: begin
        biu_exp_q.push_back({addr, line_mem[addr]});
        if (unsel == ST_DIRTY) begin
          biu_exp_q.push_back({other, line_mem[other]});
        end
      end
      default: ;
    endcase
  endfunction

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_req(input logic [2:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [WBUF_ID_W-1:0] id, input logic [CH_W-1:0] ch,
                          input logic [ROB_W-1:0] rob, input logic [1:0] s0,
                          input logic [1:0] s1, input logic [DATA_W-1:0] f0,
                          input logic [DATA_W-1:0] f1);
    req_valid_i   = 1'b1;
    req_opcode_i  = op;
    req_addr_i    = addr;
    req_wbuf_id_i = id;
    req_channel_i = ch;
    req_rob_i     = rob;
    req_state0_i  = s0;
    req_state1_i  = s1;
    req_fill0_i   = f0;
    req_fill1_i   = f1;
    // ready only moves on rising edges
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    predict(op, addr, id, ch, rob, s0, s1, f0, f1);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // only while the bank is idle, so no write fetch races the load
  task automatic load_wbuf(input logic [WBUF_ID_W-1:0] id, input logic [DATA_W-1:0] data);
    wb_wr_valid_i = 1'b1;
    wb_wr_id_i    = id;
    wb_wr_data_i  = data;
    wbuf_mem[id[WBUF_IDX_W-1:0]] = data;
    @(negedge clk_i);
    wb_wr_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (xbar_exp_q.size() != 0 || biu_exp_q.size() != 0 || cache_bank_top_inst.isu_valid) begin
      @(negedge clk_i);
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s finished with %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // --------------------------------------------------------------------------
  // crossbar and sub-memory models
  // --------------------------------------------------------------------------
  initial begin
    xbar_ready_i = 1'b1;
    biu_ready_i  = 1'b1;
    forever begin
      @(negedge clk_i);
      xbar_ready_i = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      biu_ready_i  = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  // compare every accepted beat with the oldest expected one
  initial begin
    forever begin
      @(posedge clk_i);
      if (!rst_i && xbar_valid_o && xbar_ready_i) begin
        if (xbar_exp_q.size() == 0) begin
          err_cnt++;
          $display("crossbar sent a beat that no request was waiting for at %0t", $time);
        end else begin
          xbar_exp = xbar_exp_q.pop_front();
          check_value("xbar_data_o", xbar_data_o, xbar_exp[DATA_W-1:0]);
          check_value("xbar_rob_o", DATA_W'(xbar_rob_o), DATA_W'(xbar_exp[DATA_W +: ROB_W]));
          check_value("xbar_channel_o", DATA_W'(xbar_channel_o),
                      DATA_W'(xbar_exp[DATA_W+ROB_W +: CH_W]));
        end
      end
      if (!rst_i && biu_valid_o && biu_ready_i) begin
        if (biu_exp_q.size() == 0) begin
          err_cnt++;
          $display("sub-memory got a beat that no request was waiting for at %0t", $time);
        end else begin
          biu_exp = biu_exp_q.pop_front();
          check_value("biu_data_o", biu_data_o, biu_exp[DATA_W-1:0]);
          check_value("biu_addr_o", DATA_W'(biu_addr_o), DATA_W'(biu_exp[DATA_W +: ADDR_W]));
        end
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles with outputs still pending", cycle_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [2:0] op;
    int         gap;
    void'($urandom(SEED));
    rst_i         = 1'b1;
    req_valid_i   = 1'b0;
    req_channel_i = '0;
    req_opcode_i  = '0;
    req_addr_i    = '0;
    req_wbuf_id_i = '0;
    req_rob_i     = '0;
    req_state0_i  = '0;
    req_state1_i  = '0;
    req_fill0_i   = '0;
    req_fill1_i   = '0;
    wb_wr_valid_i = 1'b0;
    wb_wr_id_i    = '0;
    wb_wr_data_i  = '0;

    @(negedge clk_i);
    check_value("req_ready_o", DATA_W'(req_ready_o), '0);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("xbar_valid_o", DATA_W'(xbar_valid_o), '0);
    check_value("biu_valid_o", DATA_W'(biu_valid_o), '0);
    check_value("req_ready_o", DATA_W'(req_ready_o), DATA_W'(1));
    end_test("reset");

    // every ram word gets known contents through linefills
    for (int i = 0; i < N_WBUF; i++) begin
      load_wbuf(WBUF_ID_W'(i), rand_word());
    end
    for (int i = 0; i < N_LINES; i++) begin
      send_req(OP_READ_LINEFILL, {(ADDR_W-1)'(i), 1'($urandom_range(0, 1))}, '0,
               CH_W'(i), ROB_W'(i), ST_EMPTY, ST_EMPTY, rand_word(), rand_word());
    end
    wait_idle();
    end_test("preload");

    load_wbuf(8'h2d, rand_word());
    send_req(OP_WRITE, 7'h13, 8'h2d, 2'd0, 3'd0, ST_SYNC, ST_SYNC, '0, '0);
    send_req(OP_READ, 7'h13, 8'h00, 2'd2, 3'd6, ST_SYNC, ST_SYNC, '0, '0);
    wait_idle();
    end_test("write then read");

    send_req(OP_READ_LINEFILL, 7'h20, '0, 2'd1, 3'd2, ST_EMPTY, ST_EMPTY, rand_word(), rand_word());
    send_req(OP_READ, 7'h20, '0, 2'd1, 3'd3, ST_SYNC, ST_SYNC, '0, '0);
    send_req(OP_READ, 7'h21, '0, 2'd1, 3'd4, ST_SYNC, ST_SYNC, '0, '0);
    wait_idle();
    end_test("linefill both offsets");

    // offset 0 of line 0x18 is sync, offset 1 of line 0x28 is dirty
    send_req(OP_READ_LINEFILL, 7'h31, '0, 2'd3, 3'd1, ST_SYNC, ST_EMPTY, rand_word(), rand_word());
    send_req(OP_READ_LINEFILL, 7'h50, '0, 2'd3, 3'd2, ST_EMPTY, ST_DIRTY, rand_word(), rand_word());
    send_req(OP_READ, 7'h30, '0, 2'd0, 3'd5, ST_SYNC, ST_SYNC, '0, '0);
    send_req(OP_READ, 7'h31, '0, 2'd0, 3'd6, ST_SYNC, ST_SYNC, '0, '0);
    send_req(OP_READ, 7'h50, '0, 2'd0, 3'd7, ST_SYNC, ST_SYNC, '0, '0);
    send_req(OP_READ, 7'h51, '0, 2'd0, 3'd0, ST_SYNC, ST_SYNC, '0, '0);
    wait_idle();
    end_test("linefill one offset");

    send_req(OP_WRITE_BACK, 7'h40, '0, 2'd0, 3'd0, ST_DIRTY, ST_DIRTY, '0, '0);
    send_req(OP_WRITE_BACK, 7'h45, '0, 2'd0, 3'd0, ST_SYNC, ST_DIRTY, '0, '0);
    send_req(OP_WRITE_BACK, 7'h47, '0, 2'd0, 3'd0, ST_DIRTY, ST_SYNC, '0, '0);
    wait_idle();
    end_test("write back");

    rand_ready = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      if (i % 50 == 0) begin
        wait_idle();
        for (int k = 0; k < N_WBUF; k++) begin
          load_wbuf(WBUF_ID_W'($urandom), rand_word());
        end
      end
      op = 3'($urandom_range(0, 3));
      send_req(op, ADDR_W'($urandom), WBUF_ID_W'($urandom), CH_W'($urandom),
               ROB_W'($urandom), 2'($urandom_range(0, 2)), 2'($urandom_range(0, 2)),
               rand_word(), rand_word());
      gap = $urandom_range(0, 3);
      repeat (gap) @(negedge clk_i);
    end
    wait_idle();
    rand_ready = 1'b0;
    end_test("random mix");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
